/* project.f */
+incdir+tb
common/scope_pkg.sv
design/axil_register_bank.sv
trigger_engine/trigger_engine.sv
design/scope_trigger_top.sv
tb/tb_scope_trigger.sv

/* run_sim.sh */
#!/bin/sh
# Builds the scope trigger testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_scope_trigger -f project.f || exit 1
./obj_dir/Vtb_scope_trigger > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

/* tb/tb_scope_tasks.svh */
// Testbench tasks for AXI4-Lite access, sample driving, the crossing model and compares
`ifndef TB_SCOPE_TASKS_SVH
`define TB_SCOPE_TASKS_SVH

// Address and data go out together, the response is taken as soon as it shows
task automatic axil_write(input logic [axil_addr_width-1:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    @(posedge clock);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
    s_wvalid  <= 1'b1;
    s_bready  <= 1'b1;
    // A ready seen at an edge is the value the slave acted on at that edge
    do begin
        @(posedge clock);
    end while (!s_awready);
    // Both channels are taken on the same edge
    check_bit("axil_write", 1'b1, s_wready);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    do begin
        @(posedge clock);
    end while (!s_bvalid);
    s_bready <= 1'b0;
    check_word("axil_write", 32'd0, {30'd0, s_bresp});
endtask

// Single read, data is taken on the edge where rvalid meets rready
task automatic axil_read(input logic [axil_addr_width-1:0] addr, output logic [31:0] data);
    @(posedge clock);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    s_rready  <= 1'b1;
    do begin
        @(posedge clock);
    end while (!s_arready);
    s_arvalid <= 1'b0;
    do begin
        @(posedge clock);
    end while (!s_rvalid);
    s_rready <= 1'b0;
    data = s_rdata;
    check_word("axil_read", 32'd0, {30'd0, s_rresp});
endtask

// One valid sample on one channel for a single cycle
// Returns half a cycle after the edge that took it, when trigger_out is settled
task automatic push_sample(input logic [2:0] ch, input logic [sample_width-1:0] data);
    @(posedge clock);
    ch_data[ch] <= data;
    ch_valid    <= n_channels'(1) << ch;
    @(posedge clock);
    ch_valid <= '0;
    @(negedge clock);
endtask

// Expected trigger for one valid sample on the selected channel
function automatic logic crossing_hit(input logic [1:0] mode, input logic [31:0] level,
                                      input logic [31:0] prev, input logic [31:0] cur);
    logic up;
    logic down;
    // Reaching the level counts, starting on it does not
    up   = (prev < level) && (cur >= level);
    down = (prev > level) && (cur <= level);
    if (mode == trig_rising) begin
        return up;
    end else if (mode == trig_falling) begin
        return down;
    end else if (mode == trig_both) begin
        return up || down;
    end
    return 1'b0;
endfunction

task automatic check_word(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
        fail_run($sformatf("Error: %s expected 0x%08h actual 0x%08h", test, expected, actual));
    end
endtask

task automatic check_bit(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
        fail_run($sformatf("Error: %s expected %b actual %b", test, expected, actual));
    end
endtask

task automatic check_state(input string test, input trig_state_t expected,
                           input trig_state_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("Error: %s expected %s actual %s", test, expected.name(),
                           actual.name()));
    end
endtask

`endif

/* tb/tb_scope_trigger.sv */
// Testbench for the scope trigger subsystem with directed register, trigger and mode tests
`timescale 1ns/10ps
`default_nettype none

module tb_scope_trigger;

    import scope_pkg::*;

    localparam int n_channels   = 6;
    localparam int memory_depth = 15;
    // The directed sequence needs about four hundred and fifty cycles
    localparam int timeout_cycles = 4000;

    logic                                     clock;
    logic                                     rst;
    logic [axil_addr_width-1:0]               s_awaddr;
    logic                                     s_awvalid;
    logic                                     s_awready;
    logic [31:0]                              s_wdata;
    logic [3:0]                               s_wstrb;
    logic                                     s_wvalid;
    logic                                     s_wready;
    logic [1:0]                               s_bresp;
    logic                                     s_bvalid;
    logic                                     s_bready;
    logic [axil_addr_width-1:0]               s_araddr;
    logic                                     s_arvalid;
    logic                                     s_arready;
    logic [31:0]                              s_rdata;
    logic [1:0]                               s_rresp;
    logic                                     s_rvalid;
    logic                                     s_rready;
    logic [n_channels-1:0][sample_width-1:0]  ch_data;
    logic [n_channels-1:0]                    ch_valid;
    logic                                     trigger_out;
    logic [15:0]                              trigger_point;
    logic [63:0]                              dma_base_addr;

    int     error_count;
    int     cycle_count;
    integer seed;
    // Last valid sample the engine has taken from the selected channel
    logic [sample_width-1:0] model_prev;

    scope_trigger_top #(
        .n_channels   (n_channels),
        .memory_depth (memory_depth)
    ) u_dut (
        .clock         (clock),
        .rst           (rst),
        .s_awaddr      (s_awaddr),
        .s_awvalid     (s_awvalid),
        .s_awready     (s_awready),
        .s_wdata       (s_wdata),
        .s_wstrb       (s_wstrb),
        .s_wvalid      (s_wvalid),
        .s_wready      (s_wready),
        .s_bresp       (s_bresp),
        .s_bvalid      (s_bvalid),
        .s_bready      (s_bready),
        .s_araddr      (s_araddr),
        .s_arvalid     (s_arvalid),
        .s_arready     (s_arready),
        .s_rdata       (s_rdata),
        .s_rresp       (s_rresp),
        .s_rvalid      (s_rvalid),
        .s_rready      (s_rready),
        .ch_data       (ch_data),
        .ch_valid      (ch_valid),
        .trigger_out   (trigger_out),
        .trigger_point (trigger_point),
        .dma_base_addr (dma_base_addr)
    );

    // Prints the failure and ends the run at once
    task automatic fail_run(input string what);
        error_count++;
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "tb_scope_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests were still running after %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $fatal(1);
    end

    task automatic test_register_access();
        logic [31:0] values [0:6];
        logic [31:0] data;
        logic [31:0] wdata;
        @(negedge clock);
        check_bit("register_access", 1'b0, trigger_out);
        check_bit("register_access", 1'b0, s_bvalid);
        check_bit("register_access", 1'b0, s_rvalid);
        axil_read(reg_rearm, data);
        check_state("register_access", st_wait_fill, trig_state_t'(data[1:0]));
        // Fill takes memory_depth+1 cycles after reset
        repeat (16) @(posedge clock);
        axil_read(reg_rearm, data);
        check_state("register_access", st_run, trig_state_t'(data[1:0]));
        for (logic [2:0] i = 0; i < 7; i++) begin
            values[i] = $random(seed);
            // Mode fields stay at rising edge and continuous acquisition
            if (i == 0 || i == 6) begin
                values[i][1:0] = 2'b00;
            end
            axil_write({i, 2'b00}, values[i], 4'hF);
        end
        for (logic [2:0] i = 0; i < 7; i++) begin
            axil_read({i, 2'b00}, data);
            check_word("register_access", values[i], data);
        end
        check_word("register_access", values[2], dma_base_addr[31:0]);
        check_word("register_access", values[3], dma_base_addr[63:32]);
        check_word("register_access", {16'd0, values[5][15:0]}, {16'd0, trigger_point});
        // Bytes 1 and 3 of the level must keep their old contents
        wdata = $random(seed);
        axil_write(reg_trigger_level, wdata, 4'b0101);
        axil_read(reg_trigger_level, data);
        check_word("register_access",
                   {values[1][31:24], wdata[23:16], values[1][15:8], wdata[7:0]}, data);
    endtask

    task automatic test_edge_triggers();
        logic [31:0] level;
        logic [31:0] rnd;
        logic [31:0] data;
        logic [2:0]  other;
        logic        expected;
        axil_write(reg_channel_select, 32'd2, 4'hF);
        axil_write(reg_acq_mode, 32'(acq_continuous), 4'hF);
        expected = 1'b0;
        // The fourth mode code is run too and must never fire
        for (int m = 0; m < 4; m++) begin
            level = $random(seed);
            axil_write(reg_trigger_mode, 32'(m), 4'hF);
            axil_write(reg_trigger_level, level, 4'hF);
            for (int n = 0; n < 30; n++) begin
                rnd  = $random(seed);
                data = $random(seed);
                // Land on the level or right next to it now and then
                case (rnd[4:2])
                    3'd0: data = level;
                    3'd1: data = level + 32'd1;
                    3'd2: data = level - 32'd1;
                    default: ;
                endcase
                if (rnd[1:0] == 2'd0) begin
                    @(posedge clock);
                    @(negedge clock);
                end else if (rnd[1:0] == 2'd1) begin
                    other = 3'((3 + int'(rnd[7:5]) % 5) % 6);
                    push_sample(other, data);
                end else begin
                    expected   = crossing_hit(m[1:0], level, model_prev, data);
                    model_prev = data;
                    push_sample(3'd2, data);
                end
                check_bit("edge_triggers", expected, trigger_out);
            end
        end
    endtask

    task automatic test_channel_select();
        axil_write(reg_trigger_mode, 32'(trig_both), 4'hF);
        axil_write(reg_trigger_level, 32'h8000_0000, 4'hF);
        // Two equal low samples leave channel 2 settled below the level
        push_sample(3'd2, 32'h0000_1000);
        push_sample(3'd2, 32'h0000_1000);
        model_prev = 32'h0000_1000;
        check_bit("channel_select", 1'b0, trigger_out);
        push_sample(3'd4, 32'h0000_1000);
        push_sample(3'd4, 32'hF000_0000);
        check_bit("channel_select", 1'b0, trigger_out);
        push_sample(3'd4, 32'h0000_1000);
        check_bit("channel_select", 1'b0, trigger_out);
        // Channel 7 does not exist, so nothing may fire
        axil_write(reg_channel_select, 32'd7, 4'hF);
        for (int c = 0; c < n_channels; c++) begin
            push_sample(3'(c), 32'hF000_0000);
            check_bit("channel_select", 1'b0, trigger_out);
        end
    endtask

    task automatic test_single_acquisition();
        logic [31:0] data;
        axil_write(reg_channel_select, 32'd2, 4'hF);
        axil_write(reg_trigger_mode, 32'(trig_rising), 4'hF);
        axil_write(reg_acq_mode, 32'(acq_single), 4'hF);
        push_sample(3'd2, 32'hF000_0000);
        check_bit("single_acquisition", 1'b1, trigger_out);
        @(negedge clock);
        check_bit("single_acquisition", 1'b0, trigger_out);
        axil_read(reg_rearm, data);
        check_state("single_acquisition", st_stop, trig_state_t'(data[1:0]));
        push_sample(3'd2, 32'h0000_1000);
        push_sample(3'd2, 32'hF000_0000);
        check_bit("single_acquisition", 1'b0, trigger_out);
        axil_write(reg_rearm, 32'd1, 4'hF);
        axil_read(reg_rearm, data);
        check_state("single_acquisition", st_run, trig_state_t'(data[1:0]));
        push_sample(3'd2, 32'h0000_1000);
        check_bit("single_acquisition", 1'b0, trigger_out);
        push_sample(3'd2, 32'hF000_0000);
        check_bit("single_acquisition", 1'b1, trigger_out);
        model_prev = 32'hF000_0000;
    endtask

    task automatic test_free_run();
        logic [31:0] data;
        axil_write(reg_acq_mode, 32'(acq_free_run), 4'hF);
        // The state changes on the edge that ends the write, the output rises one edge later
        @(posedge clock);
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            check_bit("free_run", 1'b1, trigger_out);
        end
        axil_read(reg_rearm, data);
        check_state("free_run", st_free_run, trig_state_t'(data[1:0]));
        axil_write(reg_acq_mode, 32'(acq_continuous), 4'hF);
        @(negedge clock);
        check_bit("free_run", 1'b0, trigger_out);
        axil_read(reg_rearm, data);
        check_state("free_run", st_run, trig_state_t'(data[1:0]));
    endtask

    initial begin : test_sequence
        seed        = 32'h8b81_3c05;
        error_count = 0;
        model_prev  = '0;
        rst       <= 1'b1;
        s_awaddr  <= '0;
        s_awvalid <= 1'b0;
        s_wdata   <= '0;
        s_wstrb   <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b0;
        s_araddr  <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b0;
        ch_data   <= '0;
        ch_valid  <= '0;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        test_register_access();
        test_edge_triggers();
        test_channel_select();
        test_single_acquisition();
        test_free_run();
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/scope_trigger_top.sv */
// Scope trigger top joining the AXI4-Lite register bank to the trigger engine
`timescale 1ns/10ps
`default_nettype none

module scope_trigger_top #(
    parameter int n_channels   = 6,
    parameter int memory_depth = 1023
) (
    input  logic                                                 clock,
    input  logic                                                 rst,
    // AXI4-Lite slave
    input  logic [scope_pkg::axil_addr_width-1:0]                s_awaddr,
    input  logic                                                 s_awvalid,
    output logic                                                 s_awready,
    input  logic [31:0]                                          s_wdata,
    input  logic [3:0]                                           s_wstrb,
    input  logic                                                 s_wvalid,
    output logic                                                 s_wready,
    output logic [1:0]                                           s_bresp,
    output logic                                                 s_bvalid,
    input  logic                                                 s_bready,
    input  logic [scope_pkg::axil_addr_width-1:0]                s_araddr,
    input  logic                                                 s_arvalid,
    output logic                                                 s_arready,
    output logic [31:0]                                          s_rdata,
    output logic [1:0]                                           s_rresp,
    output logic                                                 s_rvalid,
    input  logic                                                 s_rready,
    // Sample streams
    input  logic [n_channels-1:0][scope_pkg::sample_width-1:0]   ch_data,
    input  logic [n_channels-1:0]                                ch_valid,
    // Trigger and settings for the capture memory and DMA mover
    output logic                                                 trigger_out,
    output logic [15:0]                                          trigger_point,
    output logic [63:0]                                          dma_base_addr
);

    import scope_pkg::*;

    trigger_mode_t           trigger_mode;
    logic [sample_width-1:0] trigger_level;
    logic [7:0]              channel_select;
    acq_mode_t               acq_mode;
    logic                    rearm;
    trig_state_t             state;

    axil_register_bank u_regs (
        .clock          (clock),
        .rst            (rst),
        .s_awaddr       (s_awaddr),
        .s_awvalid      (s_awvalid),
        .s_awready      (s_awready),
        .s_wdata        (s_wdata),
        .s_wstrb        (s_wstrb),
        .s_wvalid       (s_wvalid),
        .s_wready       (s_wready),
        .s_bresp        (s_bresp),
        .s_bvalid       (s_bvalid),
        .s_bready       (s_bready),
        .s_araddr       (s_araddr),
        .s_arvalid      (s_arvalid),
        .s_arready      (s_arready),
        .s_rdata        (s_rdata),
        .s_rresp        (s_rresp),
        .s_rvalid       (s_rvalid),
        .s_rready       (s_rready),
        .state          (state),
        .trigger_mode   (trigger_mode),
        .trigger_level  (trigger_level),
        .dma_base_addr  (dma_base_addr),
        .channel_select (channel_select),
        .trigger_point  (trigger_point),
        .acq_mode       (acq_mode),
        .rearm          (rearm)
    );

    trigger_engine #(
        .n_channels   (n_channels),
        .memory_depth (memory_depth)
    ) u_engine (
        .clock          (clock),
        .rst            (rst),
        .ch_data        (ch_data),
        .ch_valid       (ch_valid),
        .trigger_mode   (trigger_mode),
        .trigger_level  (trigger_level),
        .channel_select (channel_select),
        .acq_mode       (acq_mode),
        .rearm          (rearm),
        .trigger_out    (trigger_out),
        .state          (state)
    );

endmodule

`default_nettype wire

/* trigger_engine/trigger_engine.sv */
// Trigger engine with channel selection, level-crossing detection and acquisition FSM
`timescale 1ns/10ps
`default_nettype none

module trigger_engine #(
    parameter int n_channels   = 6,
    parameter int memory_depth = 1023
) (
    input  logic                                                 clock,
    input  logic                                                 rst,
    // Free-running sample streams, the ADCs cannot be stalled
    input  logic [n_channels-1:0][scope_pkg::sample_width-1:0]   ch_data,
    input  logic [n_channels-1:0]                                ch_valid,
    // Configuration from the register bank
    input  scope_pkg::trigger_mode_t                             trigger_mode,
    input  logic [scope_pkg::sample_width-1:0]                   trigger_level,
    input  logic [7:0]                                           channel_select,
    input  scope_pkg::acq_mode_t                                 acq_mode,
    input  logic                                                 rearm,
    output logic                                                 trigger_out,
    output scope_pkg::trig_state_t                               state
);

    import scope_pkg::*;

    localparam int fill_width = $clog2(memory_depth + 1);

    logic [sample_width-1:0] sel_data;
    logic                    sel_valid;
    logic [sample_width-1:0] prev_sample;
    logic                    rising;
    logic                    falling;
    logic                    hit;
    logic [fill_width-1:0]   fill_cnt;

    // Channel multiplexer, an out-of-range select matches no channel
    always_comb begin
        sel_data  = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < n_channels; i++) begin
            if (channel_select == 8'(i)) begin
                sel_data  = ch_data[i];
                sel_valid = ch_valid[i];
            end
        end
    end

    // Last valid sample of the selected channel
    // It starts from zero, so the first sample is compared against ground
    always_ff @(posedge clock) begin
        if (rst) begin
            prev_sample <= '0;
        end else if (sel_valid) begin
            prev_sample <= sel_data;
        end
    end

    // Unsigned crossings, the level itself counts as reached
    assign rising  = (sel_data >= trigger_level) && (prev_sample < trigger_level);
    assign falling = (sel_data <= trigger_level) && (prev_sample > trigger_level);

    always_comb begin
        case (trigger_mode)
            trig_rising:  hit = rising;
            trig_falling: hit = falling;
            trig_both:    hit = rising || falling;
            default:      hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= st_wait_fill;
            fill_cnt    <= '0;
            trigger_out <= 1'b0;
        end else begin
            case (state)
                // Hold off until the capture memory has been written once
                st_wait_fill: begin
                    if (fill_cnt == fill_width'(memory_depth)) begin
                        state <= st_run;
                    end else begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                end
                st_run: begin
                    if (sel_valid) begin
                        trigger_out <= hit;
                    end
                    // Free-run takes priority over any pending single stop
                    if (acq_mode == acq_free_run) begin
                        state <= st_free_run;
                    end else if (acq_mode == acq_single && trigger_out) begin
                        state       <= st_stop;
                        trigger_out <= 1'b0;
                    end
                end
                // Single shot done, wait for software
                st_stop: begin
                    trigger_out <= 1'b0;
                    if (acq_mode == acq_free_run) begin
                        state <= st_free_run;
                    end else if (rearm || acq_mode != acq_single) begin
                        state <= st_run;
                    end
                end
                st_free_run: begin
                    if (acq_mode != acq_free_run) begin
                        state       <= st_run;
                        trigger_out <= 1'b0;
                    end else begin
                        trigger_out <= 1'b1;
                    end
                end
                default: state <= st_wait_fill;
            endcase
        end
    end

    // No trigger may escape before the capture memory is full
    a_no_trig_in_fill: assert property (@(posedge clock) disable iff (rst)
        state == st_wait_fill |-> !trigger_out);

    // A single acquisition fires for one cycle only
    a_single_one_cycle: assert property (@(posedge clock) disable iff (rst)
        acq_mode == acq_single && trigger_out |=> !trigger_out);

endmodule

`default_nettype wire

/* design/axil_register_bank.sv */
// AXI4-Lite register bank holding the trigger configuration and the rearm strobe
`timescale 1ns/10ps
`default_nettype none

module axil_register_bank (
    input  logic                                   clock,
    input  logic                                   rst,
    // AXI4-Lite write channels
    input  logic [scope_pkg::axil_addr_width-1:0]  s_awaddr,
    input  logic                                   s_awvalid,
    output logic                                   s_awready,
    input  logic [31:0]                            s_wdata,
    input  logic [3:0]                             s_wstrb,
    input  logic                                   s_wvalid,
    output logic                                   s_wready,
    output logic [1:0]                             s_bresp,
    output logic                                   s_bvalid,
    input  logic                                   s_bready,
    // AXI4-Lite read channels
    input  logic [scope_pkg::axil_addr_width-1:0]  s_araddr,
    input  logic                                   s_arvalid,
    output logic                                   s_arready,
    output logic [31:0]                            s_rdata,
    output logic [1:0]                             s_rresp,
    output logic                                   s_rvalid,
    input  logic                                   s_rready,
    // Engine state read back at the rearm offset
    input  scope_pkg::trig_state_t                 state,
    // Configuration outputs
    output scope_pkg::trigger_mode_t               trigger_mode,
    output logic [scope_pkg::sample_width-1:0]     trigger_level,
    output logic [63:0]                            dma_base_addr,
    output logic [7:0]                             channel_select,
    output logic [15:0]                            trigger_point,
    output scope_pkg::acq_mode_t                   acq_mode,
    output logic                                   rearm
);

    import scope_pkg::*;

    // Seven stored registers, word index taken from address bits 4:2
    logic [31:0] regs [0:6];

    logic        wr_fire;
    logic        wr_is_rearm;
    logic [2:0]  wr_index;
    logic        rd_fire;
    logic [31:0] rd_word;

    // Address and data are accepted together, and only with no response pending
    assign wr_fire     = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready   = wr_fire;
    assign s_wready    = wr_fire;
    assign wr_index    = s_awaddr[4:2];
    assign wr_is_rearm = {s_awaddr[4:2], 2'b00} == reg_rearm;

    // Every access completes with OKAY
    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= '0;
            end
            s_bvalid <= 1'b0;
            rearm    <= 1'b0;
        end else begin
            // Rearm is a single pulse on the cycle after the write is taken
            rearm <= wr_fire && wr_is_rearm;
            if (wr_fire) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            // The rearm offset has no storage behind it
            if (wr_fire && !wr_is_rearm) begin
                for (int b = 0; b < 4; b++) begin
                    if (s_wstrb[b]) begin
                        regs[wr_index][8*b +: 8] <= s_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // One read outstanding at a time
    assign s_arready = !s_rvalid;
    assign rd_fire   = s_arvalid && s_arready;

    always_comb begin
        case ({s_araddr[4:2], 2'b00})
            reg_trigger_mode:   rd_word = regs[0];
            reg_trigger_level:  rd_word = regs[1];
            reg_dma_addr_low:   rd_word = regs[2];
            reg_dma_addr_high:  rd_word = regs[3];
            reg_channel_select: rd_word = regs[4];
            reg_trigger_point:  rd_word = regs[5];
            reg_acq_mode:       rd_word = regs[6];
            reg_rearm:          rd_word = {30'd0, state};
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            s_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    // Read data is captured once and then held with rvalid
    always_ff @(posedge clock) begin
        if (rd_fire) begin
            s_rdata <= rd_word;
        end
    end

    // Register fields out to the engine and the capture blocks
    assign trigger_mode   = trigger_mode_t'(regs[0][1:0]);
    assign trigger_level  = regs[1];
    assign dma_base_addr  = {regs[3], regs[2]};
    assign channel_select = regs[4][7:0];
    assign trigger_point  = regs[5][15:0];
    assign acq_mode       = acq_mode_t'(regs[6][1:0]);

    // A response must wait for its ready before it drops
    a_bvalid_hold: assert property (@(posedge clock) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid);
    a_rvalid_hold: assert property (@(posedge clock) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

`default_nettype wire

/* common/scope_pkg.sv */
// Scope trigger package with the register map, mode and state encodings and data widths
`default_nettype none

package scope_pkg;

    // Width of one ADC sample word on every channel
    parameter int sample_width = 32;

    // Eight 32-bit registers fit in a 5-bit byte address
    parameter int axil_addr_width = 5;

    // Byte offsets of the control registers
    parameter logic [axil_addr_width-1:0] reg_trigger_mode   = 5'h00;
    parameter logic [axil_addr_width-1:0] reg_trigger_level  = 5'h04;
    parameter logic [axil_addr_width-1:0] reg_dma_addr_low   = 5'h08;
    parameter logic [axil_addr_width-1:0] reg_dma_addr_high  = 5'h0C;
    parameter logic [axil_addr_width-1:0] reg_channel_select = 5'h10;
    parameter logic [axil_addr_width-1:0] reg_trigger_point  = 5'h14;
    parameter logic [axil_addr_width-1:0] reg_acq_mode       = 5'h18;
    // Writes here rearm the engine, reads return its state
    parameter logic [axil_addr_width-1:0] reg_rearm          = 5'h1C;

    // Kind of level crossing that fires the trigger
    // The unused fourth code never fires
    typedef enum logic [1:0] {
        trig_rising  = 2'd0,
        trig_falling = 2'd1,
        trig_both    = 2'd2
    } trigger_mode_t;

    // Acquisition mode, the unused fourth code acts as continuous
    typedef enum logic [1:0] {
        acq_continuous = 2'd0,
        acq_single     = 2'd1,
        acq_free_run   = 2'd2
    } acq_mode_t;

    // Engine state as seen by software at reg_rearm
    typedef enum logic [1:0] {
        st_wait_fill = 2'd0,
        st_run       = 2'd1,
        st_stop      = 2'd2,
        st_free_run  = 2'd3
    } trig_state_t;

endpackage

`default_nettype wire
